// ==== common/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data bus and instruction word width
`define CPU_DATA_W 16

// Opcode field within the instruction word
`define CPU_OP_HI 15
`define CPU_OP_LO 12

// Memory access opcodes
`define CPU_OP_LOAD   4'h1
`define CPU_OP_LOADB  4'h2
`define CPU_OP_STORE  4'h3
`define CPU_OP_STOREB 4'h4

// All other opcodes make no bus access

`endif

// ==== common/cpuPkg.sv ====
package cpuPkg;

	// One-hot instruction phase, all zero while stopped
	typedef struct packed {
		logic fetch;
		logic decode;
		logic execute;
		logic commit;
	} phaseT;

	localparam phaseT PHASE_IDLE = '{
		fetch: 1'b0,
		decode: 1'b0,
		execute: 1'b0,
		commit: 1'b0
	};

	localparam phaseT PHASE_FETCH = '{
		fetch: 1'b1,
		decode: 1'b0,
		execute: 1'b0,
		commit: 1'b0
	};

	// Opcode field of an instruction word
	typedef logic [3:0] opcodeT;

	// Kind of data bus access for one instruction
	typedef enum logic [1:0] {
		BUS_NONE  = 2'd0,
		BUS_READ  = 2'd1,
		BUS_WRITE = 2'd2
	} busKindT;

	typedef struct packed {
		busKindT kind;
		logic    byteAccess;
	} busCmdT;

	localparam busCmdT BUS_CMD_NONE = '{
		kind: BUS_NONE,
		byteAccess: 1'b0
	};

	// Debug controls from the outside world
	typedef struct packed {
		logic stop;
		logic stepReq;
	} debugCtlT;

endpackage

// ==== hdl/phaseSequencer.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module phaseSequencer (
	input  logic                   CLK,
	input  logic                   rst,
	input  logic                   halt,
	input  cpuPkg::debugCtlT       debug,
	input  logic [`CPU_DATA_W-1:0] din,
	output cpuPkg::phaseT          phase,
	output logic [`CPU_DATA_W-1:0] instruction,
	output logic                   pcEn,
	output logic                   stopped,
	output logic                   debugActive,
	output logic                   debugStepAck
);

	logic stepPending;
	logic stepInst;
	logic stepAvail;
	logic atBoundary;
	logic holdStop;

	assign stepAvail = stepPending | debug.stepReq;

	// Next instruction may start after COMMIT, after reset or while stopped
	assign atBoundary = phase.commit | (phase == cpuPkg::PHASE_IDLE);
	assign holdStop = halt | (debug.stop & ~stepAvail);

	assign pcEn = phase.fetch;

	always_ff @(posedge CLK) begin
		if (rst) begin
			phase <= cpuPkg::PHASE_IDLE;
			stopped <= 1'b0;
			stepInst <= 1'b0;
		end else if (atBoundary) begin
			if (holdStop) begin
				phase <= cpuPkg::PHASE_IDLE;
				stopped <= 1'b1;
				stepInst <= 1'b0;
			end else begin
				phase <= cpuPkg::PHASE_FETCH;
				stopped <= 1'b0;
				// Under debug stop this can only be a stepped instruction
				stepInst <= debug.stop;
			end
		end else begin
			phase <= '{
				fetch: 1'b0,
				decode: phase.fetch,
				execute: phase.decode,
				commit: phase.execute
			};
		end
	end

	// Step request held until an instruction boundary takes it
	always_ff @(posedge CLK) begin
		if (rst) begin
			stepPending <= 1'b0;
		end else if (!debug.stop) begin
			stepPending <= 1'b0;
		end else if (atBoundary && !holdStop) begin
			stepPending <= 1'b0;
		end else if (debug.stepReq) begin
			stepPending <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			debugActive <= 1'b0;
			debugStepAck <= 1'b0;
		end else begin
			debugActive <= debug.stop;
			debugStepAck <= phase.execute & stepInst;
		end
	end

	// Fetched word
	always_ff @(posedge CLK) begin
		if (phase.fetch) begin
			instruction <= din;
		end
	end

	assert property (@(posedge CLK) disable iff (rst)
		$onehot0({phase.fetch, phase.decode, phase.execute, phase.commit}))
		else $error("phase is not one-hot");

	assert property (@(posedge CLK) disable iff (rst)
		debugStepAck |-> phase.commit)
		else $error("debugStepAck outside COMMIT");

endmodule

// ==== hdl/instructionDecoder.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module instructionDecoder (
	input  logic                   CLK,
	input  logic                   rst,
	input  cpuPkg::phaseT          phase,
	input  logic [`CPU_DATA_W-1:0] instruction,
	output cpuPkg::busCmdT         busCmd
);

	cpuPkg::opcodeT opcode;
	cpuPkg::busCmdT nextCmd;

	assign opcode = instruction[`CPU_OP_HI:`CPU_OP_LO];

	always_comb begin
		nextCmd = cpuPkg::BUS_CMD_NONE;
		case (opcode)
			`CPU_OP_LOAD: begin
				nextCmd.kind = cpuPkg::BUS_READ;
			end
			`CPU_OP_LOADB: begin
				nextCmd.kind = cpuPkg::BUS_READ;
				nextCmd.byteAccess = 1'b1;
			end
			`CPU_OP_STORE: begin
				nextCmd.kind = cpuPkg::BUS_WRITE;
			end
			`CPU_OP_STOREB: begin
				nextCmd.kind = cpuPkg::BUS_WRITE;
				nextCmd.byteAccess = 1'b1;
			end
			default: begin
				nextCmd = cpuPkg::BUS_CMD_NONE;
			end
		endcase
	end

	// Held through EXECUTE and COMMIT while the next word is fetched
	always_ff @(posedge CLK) begin
		if (rst) begin
			busCmd <= cpuPkg::BUS_CMD_NONE;
		end else if (phase.decode) begin
			busCmd <= nextCmd;
		end
	end

	assert property (@(posedge CLK) disable iff (rst)
		!(busCmd.byteAccess && busCmd.kind == cpuPkg::BUS_NONE))
		else $error("byte flag set without a bus access");

endmodule

// ==== busSequencer/busSequencer.sv ====
`timescale 1ns/100ps

module busSequencer (
	input  logic           CLK,
	input  logic           rst,
	input  cpuPkg::phaseT  phase,
	input  cpuPkg::busCmdT busCmd,
	input  logic           addr0,
	output logic           rdN,
	output logic           wrN0,
	output logic           wrN1
);

	logic readExec;
	logic writeNext;
	logic lane0;
	logic lane1;
	logic wrN0Next;
	logic wrN1Next;

	// Read strobe built only from phase and command flops
	assign readExec = phase.execute & (busCmd.kind == cpuPkg::BUS_READ);
	assign rdN = ~(phase.fetch | readExec);

	// Write lanes prepared during EXECUTE for the COMMIT phase
	assign writeNext = phase.execute & (busCmd.kind == cpuPkg::BUS_WRITE);
	assign lane0 = ~busCmd.byteAccess | ~addr0;
	assign lane1 = ~busCmd.byteAccess | addr0;

	assign wrN0Next = ~(writeNext & lane0);
	assign wrN1Next = ~(writeNext & lane1);

	always_ff @(posedge CLK) begin
		if (rst) begin
			wrN0 <= 1'b1;
			wrN1 <= 1'b1;
		end else begin
			wrN0 <= wrN0Next;
			wrN1 <= wrN1Next;
		end
	end

	assert property (@(posedge CLK) disable iff (rst)
		!(!rdN && (!wrN0 || !wrN1)))
		else $error("read and write strobes low together");

	assert property (@(posedge CLK) disable iff (rst)
		(phase == cpuPkg::PHASE_IDLE) |-> (rdN && wrN0 && wrN1))
		else $error("strobe active while stopped");

	assert property (@(posedge CLK) disable iff (rst)
		(!wrN0 || !wrN1) |-> phase.commit)
		else $error("write strobe outside COMMIT");

endmodule

// ==== hdl/busCore.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module busCore (
	input  logic                   CLK,
	input  logic                   rst,
	input  logic                   halt,
	input  cpuPkg::debugCtlT       debug,
	input  logic [`CPU_DATA_W-1:0] din,
	input  logic                   addr0,
	output cpuPkg::phaseT          phase,
	output logic [`CPU_DATA_W-1:0] instruction,
	output logic                   pcEn,
	output logic                   stopped,
	output logic                   debugActive,
	output logic                   debugStepAck,
	output logic                   rdN,
	output logic                   wrN0,
	output logic                   wrN1
);

	cpuPkg::busCmdT busCmd;

	phaseSequencer phaseSequencer_i (
		.CLK(CLK),
		.rst(rst),
		.halt(halt),
		.debug(debug),
		.din(din),
		.phase(phase),
		.instruction(instruction),
		.pcEn(pcEn),
		.stopped(stopped),
		.debugActive(debugActive),
		.debugStepAck(debugStepAck)
	);

	instructionDecoder instructionDecoder_i (
		.CLK(CLK),
		.rst(rst),
		.phase(phase),
		.instruction(instruction),
		.busCmd(busCmd)
	);

	busSequencer busSequencer_i (
		.CLK(CLK),
		.rst(rst),
		.phase(phase),
		.busCmd(busCmd),
		.addr0(addr0),
		.rdN(rdN),
		.wrN0(wrN0),
		.wrN1(wrN1)
	);

endmodule

// ==== verification/busCoreTb.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module busCoreTb;

	localparam int plannedCycles = 200;
	localparam int timeoutCycles = 2 * plannedCycles;

	localparam cpuPkg::phaseT decodePh = '{fetch: 1'b0, decode: 1'b1, execute: 1'b0, commit: 1'b0};
	localparam cpuPkg::phaseT executePh = '{fetch: 1'b0, decode: 1'b0, execute: 1'b1, commit: 1'b0};
	localparam cpuPkg::phaseT commitPh = '{fetch: 1'b0, decode: 1'b0, execute: 1'b0, commit: 1'b1};

	logic CLK = 1'b0;
	logic rst;
	logic halt;
	cpuPkg::debugCtlT debug;
	logic [`CPU_DATA_W-1:0] din = '0;
	logic addr0 = 1'b0;

	cpuPkg::phaseT phase;
	logic [`CPU_DATA_W-1:0] instruction;
	logic pcEn;
	logic stopped;
	logic debugActive;
	logic debugStepAck;
	logic rdN;
	logic wrN0;
	logic wrN1;

	integer seed = 32'h4403ff9e;
	int errors = 0;
	int cycleCount = 0;
	int commitCount = 0;

	cpuPkg::opcodeT opList[$];
	cpuPkg::opcodeT chosenOps [14] = '{4'h0, `CPU_OP_LOAD, `CPU_OP_LOADB, `CPU_OP_STORE,
		`CPU_OP_STOREB, 4'h9, `CPU_OP_STOREB, `CPU_OP_STORE, `CPU_OP_STOREB, 4'hF,
		`CPU_OP_LOAD, `CPU_OP_STOREB, 4'h5, `CPU_OP_STOREB};

	// Reference state built from the words sent on din
	logic dinPrimed = 1'b0;
	logic [`CPU_DATA_W-1:0] fetchedWord = '0;
	cpuPkg::busCmdT expCmd = cpuPkg::BUS_CMD_NONE;
	logic addr0Exec = 1'b0;
	logic stepInFlight = 1'b0;

	logic writing;
	logic expRdN;
	logic expWrN0;
	logic expWrN1;
	logic expAck;

	busCore busCore_i (
		.CLK(CLK),
		.rst(rst),
		.halt(halt),
		.debug(debug),
		.din(din),
		.addr0(addr0),
		.phase(phase),
		.instruction(instruction),
		.pcEn(pcEn),
		.stopped(stopped),
		.debugActive(debugActive),
		.debugStepAck(debugStepAck),
		.rdN(rdN),
		.wrN0(wrN0),
		.wrN1(wrN1)
	);

	always #10 CLK = ~CLK;

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
	end

	function automatic cpuPkg::busCmdT expectedCmd(input cpuPkg::opcodeT op);
		cpuPkg::busCmdT cmd;
		cmd.kind = cpuPkg::BUS_NONE;
		if (op == `CPU_OP_LOAD || op == `CPU_OP_LOADB) begin
			cmd.kind = cpuPkg::BUS_READ;
		end
		if (op == `CPU_OP_STORE || op == `CPU_OP_STOREB) begin
			cmd.kind = cpuPkg::BUS_WRITE;
		end
		cmd.byteAccess = (op == `CPU_OP_LOADB) || (op == `CPU_OP_STOREB);
		return cmd;
	endfunction

	function automatic cpuPkg::opcodeT nextOp();
		if (opList.size() == 0) begin
			return 4'h0;
		end
		return opList.pop_front();
	endfunction

	// Chosen opcode over random operand bits
	function automatic logic [`CPU_DATA_W-1:0] makeWord(input cpuPkg::opcodeT op);
		logic [31:0] r;
		r = $random(seed);
		return {op, r[`CPU_OP_LO-1:0]};
	endfunction

	function automatic logic randomBit();
		logic [31:0] r;
		r = $random(seed);
		return r[0];
	endfunction

	task automatic reportMismatch(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	always @(posedge CLK) begin
		addr0 <= randomBit();
		if (phase.fetch || !dinPrimed) begin
			din <= makeWord(nextOp());
			dinPrimed <= 1'b1;
		end
		if (phase.fetch) begin
			fetchedWord <= din;
			expCmd <= expectedCmd(din[`CPU_OP_HI:`CPU_OP_LO]);
		end
		if (phase.execute) begin
			addr0Exec <= addr0;
		end
		if (phase.commit) begin
			commitCount <= commitCount + 1;
		end
		if (stopped && debug.stop && debug.stepReq && !halt) begin
			stepInFlight <= 1'b1;
		end else if (phase.commit) begin
			stepInFlight <= 1'b0;
		end
	end

	assign expRdN = !(phase.fetch || (phase.execute && expCmd.kind == cpuPkg::BUS_READ));
	assign writing = phase.commit && expCmd.kind == cpuPkg::BUS_WRITE;
	assign expWrN0 = !(writing && (!expCmd.byteAccess || !addr0Exec));
	assign expWrN1 = !(writing && (!expCmd.byteAccess || addr0Exec));
	assign expAck = phase.commit && stepInFlight;

	assert property (@(posedge CLK) (rst && cycleCount > 0) |-> (phase == cpuPkg::PHASE_IDLE
		&& !stopped && !pcEn && !debugStepAck && rdN && wrN0 && wrN1))
		else reportMismatch("outputs not at reset values");

	// Phase ring
	assert property (@(posedge CLK) disable iff (rst) phase.fetch |=> phase == decodePh)
		else reportMismatch("FETCH not followed by DECODE");
	assert property (@(posedge CLK) disable iff (rst) phase.decode |=> phase == executePh)
		else reportMismatch("DECODE not followed by EXECUTE");
	assert property (@(posedge CLK) disable iff (rst) phase.execute |=> phase == commitPh)
		else reportMismatch("EXECUTE not followed by COMMIT");
	assert property (@(posedge CLK) disable iff (rst)
		phase.commit && !halt && !debug.stop |=> phase == cpuPkg::PHASE_FETCH)
		else reportMismatch("COMMIT not followed by FETCH");
	assert property (@(posedge CLK) disable iff (rst)
		(phase == cpuPkg::PHASE_IDLE) && !halt && !debug.stop |=> phase == cpuPkg::PHASE_FETCH)
		else reportMismatch("no FETCH after release");

	assert property (@(posedge CLK) disable iff (rst) pcEn == phase.fetch)
		else reportMismatch("pcEn differs from FETCH");
	assert property (@(posedge CLK) disable iff (rst) phase.decode |-> instruction == fetchedWord)
		else reportMismatch("instruction differs from fetched word");

	// Strobes
	assert property (@(posedge CLK) disable iff (rst) rdN == expRdN)
		else reportMismatch("rdN wrong");
	assert property (@(posedge CLK) disable iff (rst) wrN0 == expWrN0)
		else reportMismatch("wrN0 wrong");
	assert property (@(posedge CLK) disable iff (rst) wrN1 == expWrN1)
		else reportMismatch("wrN1 wrong");

	// Halt
	assert property (@(posedge CLK) disable iff (rst) phase.commit && halt
		|=> stopped && phase == cpuPkg::PHASE_IDLE && rdN && wrN0 && wrN1)
		else reportMismatch("halt did not stop after COMMIT");
	assert property (@(posedge CLK) disable iff (rst)
		stopped && halt |=> stopped && phase == cpuPkg::PHASE_IDLE)
		else reportMismatch("ran while halted");

	// Debug stop and step
	assert property (@(posedge CLK) disable iff (rst) debugActive == $past(debug.stop))
		else reportMismatch("debugActive wrong");
	assert property (@(posedge CLK) disable iff (rst) phase.commit && debug.stop && !halt
		|=> stopped && phase == cpuPkg::PHASE_IDLE)
		else reportMismatch("no stop after COMMIT under debug stop");
	assert property (@(posedge CLK) disable iff (rst) stopped && debug.stop && !debug.stepReq
		&& !halt |=> stopped && phase == cpuPkg::PHASE_IDLE)
		else reportMismatch("ran under debug stop without a step");
	assert property (@(posedge CLK) disable iff (rst) stopped && debug.stop && debug.stepReq
		&& !halt |=> phase == cpuPkg::PHASE_FETCH)
		else reportMismatch("step request did not start FETCH");
	assert property (@(posedge CLK) disable iff (rst) debugStepAck == expAck)
		else reportMismatch("debugStepAck wrong");

	task automatic waitInstructions(input int count);
		int seen;
		seen = 0;
		while (seen < count) begin
			@(posedge CLK);
			if (phase.commit) begin
				seen++;
			end
		end
	endtask

	task automatic waitStopped();
		do begin
			@(posedge CLK);
		end while (!stopped);
	endtask

	task automatic stepOnce();
		@(posedge CLK);
		debug.stepReq <= 1'b1;
		@(posedge CLK);
		debug.stepReq <= 1'b0;
		waitInstructions(1);
		waitStopped();
	endtask

	initial begin
		rst = 1'b1;
		halt = 1'b0;
		debug = '{stop: 1'b0, stepReq: 1'b0};
		repeat (2) begin
			foreach (chosenOps[i]) begin
				opList.push_back(chosenOps[i]);
			end
		end
		repeat (10) @(posedge CLK);
		rst <= 1'b0;
		waitInstructions(14);

		halt <= 1'b1;
		waitStopped();
		repeat (5) @(posedge CLK);
		halt <= 1'b0;
		waitInstructions(3);

		debug.stop <= 1'b1;
		waitStopped();
		repeat (4) @(posedge CLK);
		repeat (3) stepOnce();
		repeat (2) @(posedge CLK);
		debug.stop <= 1'b0;
		waitInstructions(3);
		repeat (2) @(posedge CLK);

		$display("Summary: %0d errors, %0d instructions, %0d cycles",
			errors, commitCount, cycleCount);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		while (cycleCount < timeoutCycles) begin
			@(posedge CLK);
		end
		$display("Timeout: test sequence did not finish within %0d cycles", timeoutCycles);
		$display("Summary: %0d errors, %0d instructions, %0d cycles",
			errors, commitCount, cycleCount);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+common
common/cpuPkg.sv
hdl/phaseSequencer.sv
hdl/instructionDecoder.sv
busSequencer/busSequencer.sv
hdl/busCore.sv
verification/busCoreTb.sv

// ==== Makefile ====
TOP = busCoreTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | awk '{ print } /All tests passed!/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
